/* design/bootCtrl.sv */
`timescale 1ns/1ps

module bootCtrl (
  input  logic             CLK,
  input  logic             arstN,
  input  logic             start,
  input  logic             segDone,
  input  logic             loadEnd,
  output logic             segRun,
  output fePkg::tScriptSeg seg,
  output logic             loadEn,
  output logic             bootDone
);
  import fePkg::*;

  typedef enum logic [2:0] {
    idle,
    resetScript,
    loading,
    startScript,
    done
  } tBootState;

  tBootState state;

  ////////////////////////////////////////////////////////////////////////////
  // Boot order
  // Reset script, image load, start script
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state    <= idle;
      segRun   <= 1'b0;
      seg      <= segReset;
      loadEn   <= 1'b0;
      bootDone <= 1'b0;
    end else begin
      segRun <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            segRun <= 1'b1;
            seg    <= segReset;
            state  <= resetScript;
          end
        end
        resetScript: begin
          // Bytes start to flow once master reset is through
          if (segDone) begin
            loadEn <= 1'b1;
            state  <= loading;
          end
        end
        loading: begin
          if (loadEnd) begin
            loadEn <= 1'b0;
            segRun <= 1'b1;
            seg    <= segStart;
            state  <= startScript;
          end
        end
        startScript: begin
          if (segDone) begin
            bootDone <= 1'b1;
            state    <= done;
          end
        end
        // Held until the next reset
        default: state <= done;
      endcase
    end
  end

  aLoadOnlyLoading: assert property (@(posedge CLK) disable iff (!arstN) loadEn |-> state == loading)
    else $error("loadEn high outside the loading state");

endmodule

/* design/bootPkg.sv */
package bootPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Machine word and its halves
  typedef logic [17:0] tHalf;
  typedef logic [35:0] tWord;

  // One write into main memory
  // No back-pressure so valid alone qualifies it
  typedef struct packed {
    logic valid;
    tHalf addr;
    tWord data;
  } tMemWrite;

  // Summary of a finished load
  // Start word also lands at address 0
  // Address range covers data words only
  typedef struct packed {
    tWord startWord;
    tHalf minAddr;
    tHalf maxAddr;
  } tLoadStats;

  // Left halves at or above this value are IOWD block headers
  localparam tHalf IowdMin = 18'o400000;

endpackage

/* design/diagSequencer.sv */
`timescale 1ns/1ps

module diagSequencer #(
  parameter int DiagHoldCycles = 9,
  parameter int DiagGapCycles  = 4
) (
  input  logic             CLK,
  input  logic             arstN,
  input  logic             segRun,
  input  fePkg::tScriptSeg seg,
  output fePkg::tDiagBus   diagBus,
  output logic             segDone
);
  import fePkg::*;

  localparam int CntMax = (DiagHoldCycles > DiagGapCycles) ? DiagHoldCycles : DiagGapCycles;
  localparam int CntW = $clog2(CntMax + 1);
  localparam int NumSteps = 23;

  // Segment bounds inside the script table
  localparam logic [4:0] ResetFirst = 5'd0;
  localparam logic [4:0] ResetLast  = 5'd16;
  localparam logic [4:0] StartFirst = 5'd17;
  localparam logic [4:0] StartLast  = 5'd22;

  typedef struct packed {
    tDiagFunction func;
    logic         driving;
    logic [17:0]  dataRh;
  } tScriptStep;

  ////////////////////////////////////////////////////////////////////////////
  // Script table
  // Master reset first, then the start sequence
  localparam tScriptStep ScriptRom [NumSteps] = '{
    '{clrRun,       1'b0, 18'o000000},
    '{ldClkSrc,     1'b1, 18'o000010},   // External clock, no divider
    '{stopClock,    1'b0, 18'o000000},
    '{setReset,     1'b0, 18'o000000},
    '{ldParChk,     1'b0, 18'o000000},
    '{ldMboxDis,    1'b0, 18'o000000},
    '{ldBurstRh,    1'b0, 18'o000000},
    '{ldBurstLh,    1'b0, 18'o000000},
    '{ldEboxDis,    1'b0, 18'o000000},
    '{startClock,   1'b0, 18'o000000},
    '{initChannels, 1'b0, 18'o000000},
    '{ldBurstRh,    1'b0, 18'o000000},
    '{condStep,     1'b0, 18'o000000},
    '{clrReset,     1'b0, 18'o000000},
    '{enableKl,     1'b0, 18'o000000},
    '{memReset,     1'b0, 18'o000000},
    '{writeMbox,    1'b1, 18'o001402},
    '{ldMboxDis,    1'b1, 18'o000003},   // Start segment begins here
    '{ldParChk,     1'b1, 18'o000016},
    '{startClock,   1'b0, 18'o000000},
    '{setRun,       1'b0, 18'o000000},
    '{continueBtn,  1'b0, 18'o000000},
    '{startClock,   1'b0, 18'o000000}
  };

  logic            running;
  logic            inStrobe;
  logic [CntW-1:0] phaseCnt;
  logic [4:0]      stepIdx;
  logic [4:0]      lastIdx;
  tScriptSeg       curSeg;
  tScriptStep      curStep;
  logic            holdEnd;
  logic            gapEnd;
  logic            strobeOn;

  assign curStep  = ScriptRom[stepIdx];
  assign holdEnd  = phaseCnt == CntW'(DiagHoldCycles - 1);
  assign gapEnd   = phaseCnt == CntW'(DiagGapCycles - 1);
  assign lastIdx  = (curSeg == segReset) ? ResetLast : StartLast;
  assign strobeOn = running & inStrobe;

  // Strobe phase then gap phase for every step
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      running  <= 1'b0;
      inStrobe <= 1'b0;
      phaseCnt <= '0;
      stepIdx  <= ResetFirst;
      curSeg   <= segReset;
    end else if (!running) begin
      if (segRun) begin
        running  <= 1'b1;
        inStrobe <= 1'b1;
        phaseCnt <= '0;
        curSeg   <= seg;
        stepIdx  <= (seg == segReset) ? ResetFirst : StartFirst;
      end
    end else if (inStrobe) begin
      if (holdEnd) begin
        inStrobe <= 1'b0;
        phaseCnt <= '0;
      end else begin
        phaseCnt <= phaseCnt + 1'b1;
      end
    end else if (gapEnd) begin
      phaseCnt <= '0;
      // Last gap of the segment ends the run
      if (stepIdx == lastIdx) begin
        running <= 1'b0;
      end else begin
        stepIdx  <= stepIdx + 1'b1;
        inStrobe <= 1'b1;
      end
    end else begin
      phaseCnt <= phaseCnt + 1'b1;
    end
  end

  // Bus fields follow the current step only while strobing
  always_comb begin
    diagBus.diagStrobe = strobeOn;
    diagBus.ds         = strobeOn ? curStep.func : diagIdle;
    diagBus.driving    = strobeOn & curStep.driving;
    diagBus.dataRh     = (strobeOn && curStep.driving) ? curStep.dataRh : '0;
  end

  assign segDone = running & ~inStrobe & gapEnd & (stepIdx == lastIdx);

  // Boot control waits for segDone before the next launch
  aSegRunIdle: assert property (@(posedge CLK) disable iff (!arstN) segRun |-> !running)
    else $error("segRun while a script segment is still running");

endmodule

/* design/feBootTop.sv */
`timescale 1ns/1ps

module feBootTop #(
  parameter int DiagHoldCycles = 9,
  parameter int DiagGapCycles  = 4,
  parameter int ByteFifoDepth  = 4
) (
  input  logic               CLK,
  input  logic               arstN,
  input  logic               start,
  output logic               bootDone,
  input  logic               byteValid,
  input  logic [7:0]         byteData,
  output logic               creditReturn,
  output fePkg::tDiagBus     diagBus,
  output bootPkg::tMemWrite  memWr,
  output bootPkg::tLoadStats stats
);
  import fePkg::*;
  import bootPkg::*;

  // Script handshake
  logic      segRun;
  logic      segDone;
  tScriptSeg seg;

  // Load path
  logic loadEn;
  logic loadEnd;
  tWord word;
  logic wordValid;

  bootCtrl uBootCtrl (
    .CLK(CLK), .arstN(arstN), .start(start), .segDone(segDone), .loadEnd(loadEnd),
    .segRun(segRun), .seg(seg), .loadEn(loadEn), .bootDone(bootDone)
  );

  diagSequencer #(.DiagHoldCycles(DiagHoldCycles), .DiagGapCycles(DiagGapCycles)) uDiagSeq (
    .CLK(CLK), .arstN(arstN), .segRun(segRun), .seg(seg),
    .diagBus(diagBus), .segDone(segDone)
  );

  wordAssembler #(.ByteFifoDepth(ByteFifoDepth)) uWordAsm (
    .CLK(CLK), .arstN(arstN), .loadEn(loadEn), .byteValid(byteValid), .byteData(byteData),
    .creditReturn(creditReturn), .word(word), .wordValid(wordValid)
  );

  iowdParser uIowdParser (
    .CLK(CLK), .arstN(arstN), .word(word), .wordValid(wordValid),
    .memWr(memWr), .loadEnd(loadEnd), .stats(stats)
  );

endmodule

/* design/fePkg.sv */
package fePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic function codes in octal as the front end issues them
  typedef enum logic [6:0] {
    stopClock    = 7'o000,
    startClock   = 7'o001,
    condStep     = 7'o004,
    clrReset     = 7'o006,
    setReset     = 7'o007,
    clrRun       = 7'o010,
    setRun       = 7'o011,
    continueBtn  = 7'o012,
    ldBurstRh    = 7'o042,
    ldBurstLh    = 7'o043,
    ldClkSrc     = 7'o044,
    ldEboxDis    = 7'o045,
    ldParChk     = 7'o046,
    ldMboxDis    = 7'o047,
    enableKl     = 7'o067,
    initChannels = 7'o070,
    writeMbox    = 7'o071,
    memReset     = 7'o076,
    diagIdle     = 7'o177
  } tDiagFunction;

  // Diagnostic bus as seen by the processor
  // dataRh only carries a value while driving is set
  typedef struct packed {
    logic         diagStrobe;
    tDiagFunction ds;
    logic         driving;
    logic [17:0]  dataRh;
  } tDiagBus;

  // Script segments played around the image load
  typedef enum logic {
    segReset,
    segStart
  } tScriptSeg;

endpackage

/* design/iowdParser.sv */
`timescale 1ns/1ps

module iowdParser (
  input  logic               CLK,
  input  logic               arstN,
  input  bootPkg::tWord      word,
  input  logic               wordValid,
  output bootPkg::tMemWrite  memWr,
  output logic               loadEnd,
  output bootPkg::tLoadStats stats
);
  import bootPkg::*;

  tHalf leftHalf;
  tHalf rightHalf;
  tHalf remaining;
  tHalf curAddr;
  tHalf minAddr;
  tHalf maxAddr;
  tHalf wrAddr;
  tWord wrData;
  tWord startWord;
  logic wrValid;
  logic isHeader;
  logic isBlock;
  logic isData;

  assign leftHalf  = word[35:18];
  assign rightHalf = word[17:0];

  // No words left in the block means this one is a header
  assign isHeader = wordValid && (remaining == '0);
  assign isData   = wordValid && (remaining != '0);
  assign isBlock  = leftHalf >= IowdMin;

  ////////////////////////////////////////////////////////////////////////////
  // Block state and address range
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      remaining <= '0;
      curAddr   <= '0;
      wrValid   <= 1'b0;
      loadEnd   <= 1'b0;
      minAddr   <= '1;
      maxAddr   <= '0;
    end else begin
      wrValid <= 1'b0;
      loadEnd <= 1'b0;
      if (isHeader) begin
        if (isBlock) begin
          // Block length is 2^18 minus the negative left half
          remaining <= tHalf'(18'd0 - leftHalf);
          curAddr   <= rightHalf;
        end else begin
          // Start word goes to address 0 and ends the load
          wrValid <= 1'b1;
          loadEnd <= 1'b1;
        end
      end else if (isData) begin
        wrValid   <= 1'b1;
        curAddr   <= curAddr + 1'b1;
        remaining <= remaining - 1'b1;
        if (curAddr < minAddr) minAddr <= curAddr;
        if (curAddr > maxAddr) maxAddr <= curAddr;
      end
    end
  end

  // Write payload and start word
  always_ff @(posedge CLK) begin
    if (isHeader && !isBlock) begin
      wrAddr    <= '0;
      wrData    <= word;
      startWord <= word;
    end else if (isData) begin
      wrAddr <= curAddr;
      wrData <= word;
    end
  end

  assign memWr = '{valid: wrValid, addr: wrAddr, data: wrData};
  assign stats = '{startWord: startWord, minAddr: minAddr, maxAddr: maxAddr};

endmodule

/* design/wordAssembler.sv */
`timescale 1ns/1ps

module wordAssembler #(
  parameter int ByteFifoDepth = 4
) (
  input  logic          CLK,
  input  logic          arstN,
  input  logic          loadEn,
  input  logic          byteValid,
  input  logic [7:0]    byteData,
  output logic          creditReturn,
  output bootPkg::tWord word,
  output logic          wordValid
);
  import bootPkg::*;

  localparam int PtrW = (ByteFifoDepth > 1) ? $clog2(ByteFifoDepth) : 1;
  localparam int CntW = $clog2(ByteFifoDepth + 1);

  logic [7:0]      fifoMem [ByteFifoDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] fillCnt;
  logic            fifoFull;
  logic            pop;
  logic [7:0]      popByte;
  logic [2:0]      byteIdx;
  tWord            shiftReg;

  // Pointer step with wrap for any depth
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(ByteFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fifoFull = fillCnt == CntW'(ByteFifoDepth);
  assign pop      = loadEn && (fillCnt != '0);
  assign popByte  = fifoMem[rdPtr];

  ////////////////////////////////////////////////////////////////////////////
  // Byte FIFO
  // Host only sends against credits, so a push is always accepted
  always_ff @(posedge CLK) begin
    if (byteValid) fifoMem[wrPtr] <= byteData;
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      fillCnt      <= '0;
      creditReturn <= 1'b0;
      byteIdx      <= '0;
      wordValid    <= 1'b0;
    end else begin
      if (byteValid) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      case ({byteValid, pop})
        2'b10:   fillCnt <= fillCnt + 1'b1;
        2'b01:   fillCnt <= fillCnt - 1'b1;
        default: fillCnt <= fillCnt;
      endcase
      // Each pop frees one slot back to the host
      creditReturn <= pop;
      wordValid    <= pop && (byteIdx == 3'd4);
      if (pop) byteIdx <= (byteIdx == 3'd4) ? 3'd0 : byteIdx + 1'b1;
    end
  end

  // Big-endian packing where the fifth byte gives only its upper nibble
  always_ff @(posedge CLK) begin
    if (pop) begin
      if (byteIdx == 3'd4) shiftReg <= {shiftReg[31:0], popByte[7:4]};
      else                 shiftReg <= {shiftReg[27:0], popByte};
    end
  end

  assign word = shiftReg;

  // Overflow here means the host sent without a credit
  aNoOverflow: assert property (@(posedge CLK) disable iff (!arstN) byteValid |-> !fifoFull)
    else $error("byte pushed into a full FIFO, credit rule broken");

endmodule

/* project.f */
design/fePkg.sv
design/bootPkg.sv
design/diagSequencer.sv
design/wordAssembler.sv
design/iowdParser.sv
design/bootCtrl.sv
design/feBootTop.sv
verif/tbChecker.sv
verif/tbTop.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f project.f -o simv

# The log decides the result, not the exit status of the run
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
fi
exit 1

/* verif/tbChecker.sv */
`timescale 1ns/1ps

module tbChecker #(
  parameter int DiagHoldCycles = 9,
  parameter int DiagGapCycles  = 4,
  parameter int ByteFifoDepth  = 4
) (
  input  logic               CLK,
  input  logic               arstN,
  input  fePkg::tDiagBus     diagBus,
  input  bootPkg::tMemWrite  memWr,
  input  bootPkg::tLoadStats stats,
  input  logic               bootDone,
  input  logic               byteValid,
  input  logic               creditReturn,
  input  bootPkg::tWord      image [64],
  input  int                 imageLen,
  output logic               checksDone,
  output int                 failCount
);
  import fePkg::*;
  import bootPkg::*;

  localparam int NumSteps = 23;
  localparam int NumReset = 17;
  localparam int DoneHold = 10;
  localparam int TReset   = 0;
  localparam int TTiming  = 1;
  localparam int TWrites  = 2;
  localparam int TCredits = 3;
  localparam int TEnd     = 4;

  string testName [5] = '{"resetScript", "strobeTiming", "memWrites", "credits", "endOfBoot"};

  ////////////////////////////////////////////////////////////////////////////
  // Script model of the reset segment then the start segment
  tDiagFunction scriptFunc [NumSteps] = '{
    clrRun, ldClkSrc, stopClock, setReset, ldParChk, ldMboxDis, ldBurstRh, ldBurstLh,
    ldEboxDis, startClock, initChannels, ldBurstRh, condStep, clrReset, enableKl, memReset,
    writeMbox, ldMboxDis, ldParChk, startClock, setRun, continueBtn, startClock
  };

  localparam tDiagBus IdleBus = '{diagStrobe: 1'b0, ds: diagIdle, driving: 1'b0, dataRh: '0};

  int        errs [5];
  logic      reported [5];
  int        stepCount;
  int        strobeLen;
  int        gapLen;
  logic      prevStrobe;
  tDiagBus   heldBus;
  tHalf      expAddr [64];
  tWord      expData [64];
  int        expCount;
  int        wrIdx;
  tLoadStats expStats;
  int        sent;
  int        returned;
  int        doneCycles;
  logic      resetDone;
  logic      startSeen;

  // Only four steps drive the right half
  function automatic tDiagBus expectedBus(input int idx);
    tDiagBus b;
    b.diagStrobe = 1'b1;
    b.ds         = scriptFunc[idx];
    b.driving    = 1'b1;
    case (idx)
      1:  b.dataRh = 18'o000010;
      16: b.dataRh = 18'o001402;
      17: b.dataRh = 18'o000003;
      18: b.dataRh = 18'o000016;
      default: begin
        b.driving = 1'b0;
        b.dataRh  = '0;
      end
    endcase
    return b;
  endfunction

  task automatic valueFail(input int t, input string what, input logic [71:0] exp,
                           input logic [71:0] act);
    errs[t]++;
    $display("[FAIL] %s (%s): expected %0o, actual %0o", testName[t], what, exp, act);
  endtask

  task automatic eventFail(input int t, input string what);
    errs[t]++;
    $display("Error in %s: %s", testName[t], what);
  endtask

  task automatic reportTest(input int t);
    reported[t] = 1'b1;
    $display("Test %-12s %s (%0d errors)", testName[t], (errs[t] == 0) ? "PASS" : "FAIL",
             errs[t]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected writes from the IOWD rule
  task automatic buildModel();
    tHalf left;
    tHalf addr;
    tHalf remaining;
    expCount  = 0;
    remaining = '0;
    addr      = '0;
    expStats  = '{startWord: '0, minAddr: '1, maxAddr: '0};
    for (int i = 0; i < imageLen; i++) begin
      left = image[i][35:18];
      if (remaining != '0) begin
        expAddr[expCount] = addr;
        expData[expCount] = image[i];
        expCount++;
        if (addr < expStats.minAddr) expStats.minAddr = addr;
        if (addr > expStats.maxAddr) expStats.maxAddr = addr;
        addr      = addr + 18'd1;
        remaining = remaining - 18'd1;
      end else if (left >= 18'o400000) begin
        // Count is 2^18 minus the left half
        remaining = 18'd0 - left;
        addr      = image[i][17:0];
      end else begin
        expAddr[expCount] = '0;
        expData[expCount] = image[i];
        expCount++;
        expStats.startWord = image[i];
        break;
      end
    end
  endtask

  // Strobe order, field stability, hold and gap widths
  task automatic checkDiag();
    tDiagBus exp;
    if (diagBus.diagStrobe) begin
      if (!prevStrobe) begin
        if (stepCount >= NumSteps) begin
          eventFail(TTiming, "strobe seen after the start script ended");
        end else begin
          exp = expectedBus(stepCount);
          if (diagBus !== exp)
            valueFail((stepCount < NumReset) ? TReset : TEnd, $sformatf("step %0d", stepCount),
                      64'(exp), 64'(diagBus));
        end
        // Gaps between segments are open ended
        if (stepCount != 0 && stepCount != NumReset && gapLen != DiagGapCycles)
          valueFail(TTiming, "gap width", 64'(DiagGapCycles), 64'(gapLen));
        heldBus   = diagBus;
        strobeLen = 1;
      end else begin
        strobeLen++;
        if (diagBus !== heldBus) valueFail(TTiming, "held fields", 64'(heldBus), 64'(diagBus));
      end
    end else begin
      if (diagBus !== IdleBus) valueFail(TTiming, "idle bus", 64'(IdleBus), 64'(diagBus));
      if (prevStrobe) begin
        if (strobeLen != DiagHoldCycles)
          valueFail(TTiming, "strobe width", 64'(DiagHoldCycles), 64'(strobeLen));
        stepCount++;
        gapLen = 1;
        if (stepCount == NumReset) begin
          resetDone = 1'b1;
          reportTest(TReset);
        end
      end else begin
        gapLen++;
      end
    end
    prevStrobe = diagBus.diagStrobe;
  endtask

  task automatic checkWrite();
    if (memWr.valid) begin
      if (!resetDone) eventFail(TCredits, "memory write before the reset script ended");
      if (memWr.addr == '0 && memWr.data == expStats.startWord) startSeen = 1'b1;
      if (wrIdx >= expCount) begin
        eventFail(TWrites, "memory write beyond the expected list");
      end else begin
        if ({memWr.addr, memWr.data} !== {expAddr[wrIdx], expData[wrIdx]})
          valueFail(TWrites, $sformatf("write %0d", wrIdx), 64'({expAddr[wrIdx], expData[wrIdx]}),
                    64'({memWr.addr, memWr.data}));
        wrIdx++;
        if (wrIdx == expCount) reportTest(TWrites);
      end
    end
  endtask

  // Host credits are depth minus bytes in flight
  task automatic checkCredits();
    if (creditReturn) returned++;
    if (byteValid) begin
      if (sent - returned >= ByteFifoDepth) eventFail(TCredits, "byte sent without a credit");
      sent++;
    end
  endtask

  task automatic finalReport();
    int passed;
    if (wrIdx != expCount)
      eventFail(TWrites, $sformatf("only %0d of %0d writes seen", wrIdx, expCount));
    if (!startSeen) eventFail(TEnd, "start word never written to address 0");
    if (stats !== expStats) valueFail(TEnd, "stats", expStats, stats);
    if (sent != imageLen * 5) valueFail(TCredits, "bytes sent", 64'(imageLen * 5), 64'(sent));
    if (returned != sent) valueFail(TCredits, "credits returned", 64'(sent), 64'(returned));
    passed = 0;
    for (int t = 0; t < 5; t++) begin
      if (!reported[t]) reportTest(t);
      if (errs[t] == 0) passed++;
    end
    failCount = 5 - passed;
    $display("Tests run: 5, passed: %0d, failed: %0d", passed, failCount);
    checksDone = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sampled on the rising edge while inputs settle 1 ns after it
  always @(posedge CLK) begin
    if (!arstN) begin
      checksDone = 1'b0;
      failCount  = 0;
      stepCount  = 0;
      strobeLen  = 0;
      gapLen     = 0;
      prevStrobe = 1'b0;
      wrIdx      = 0;
      sent       = 0;
      returned   = 0;
      doneCycles = 0;
      resetDone  = 1'b0;
      startSeen  = 1'b0;
      for (int t = 0; t < 5; t++) begin
        errs[t]     = 0;
        reported[t] = 1'b0;
      end
      buildModel();
    end else if (!checksDone) begin
      checkDiag();
      checkWrite();
      checkCredits();
      // bootDone must follow the whole start script and then hold
      if (bootDone) begin
        if (doneCycles == 0 && stepCount != NumSteps)
          eventFail(TEnd, "bootDone rose before the start script finished");
        doneCycles++;
        if (doneCycles == DoneHold) finalReport();
      end else if (doneCycles != 0) begin
        eventFail(TEnd, "bootDone dropped after rising");
        finalReport();
      end
    end
  end

endmodule

/* verif/tbTop.sv */
`timescale 1ns/1ps

module tbTop;
  import fePkg::*;
  import bootPkg::*;

  localparam int DiagHoldCycles = 9;
  localparam int DiagGapCycles  = 4;
  localparam int ByteFifoDepth  = 4;
  localparam int MaxWords       = 64;

  logic       CLK;
  logic       arstN;
  logic       start;
  logic       byteValid;
  logic [7:0] byteData;
  logic       creditReturn;
  logic       bootDone;
  tDiagBus    diagBus;
  tMemWrite   memWr;
  tLoadStats  stats;

  // Boot image as words that the host serialises
  tWord image [MaxWords];
  int   imageLen;
  int   cycleCnt;
  int   cycleLimit;
  logic checksDone;
  int   failCount;

  feBootTop #(
    .DiagHoldCycles(DiagHoldCycles), .DiagGapCycles(DiagGapCycles), .ByteFifoDepth(ByteFifoDepth)
  ) DUT (
    .CLK(CLK), .arstN(arstN), .start(start), .bootDone(bootDone), .byteValid(byteValid),
    .byteData(byteData), .creditReturn(creditReturn), .diagBus(diagBus), .memWr(memWr),
    .stats(stats)
  );

  tbChecker #(
    .DiagHoldCycles(DiagHoldCycles), .DiagGapCycles(DiagGapCycles), .ByteFifoDepth(ByteFifoDepth)
  ) uChecker (
    .CLK(CLK), .arstN(arstN), .diagBus(diagBus), .memWr(memWr), .stats(stats),
    .bootDone(bootDone), .byteValid(byteValid), .creditReturn(creditReturn), .image(image),
    .imageLen(imageLen), .checksDone(checksDone), .failCount(failCount)
  );

  function automatic void addWord(input tWord w);
    image[imageLen] = w;
    imageLen++;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Random image
  // Blocks climb in address with random holes so none overlap
  task automatic buildImage();
    int   nBlocks;
    int   nWords;
    tHalf addr;
    nBlocks = 3 + ($urandom % 4);
    addr    = 18'o000100 + tHalf'($urandom % 64);
    for (int b = 0; b < nBlocks; b++) begin
      nWords = 1 + ($urandom % 8);
      // IOWD header with the negative count on the left
      addWord({-tHalf'(nWords), addr});
      for (int i = 0; i < nWords; i++) begin
        addWord(tWord'({$urandom, $urandom}));
      end
      addr = addr + tHalf'(nWords) + tHalf'($urandom % 32);
    end
    // Start word keeps its left half positive
    addWord({tHalf'($urandom) & 18'o377777, tHalf'($urandom)});
  endtask

  // Five big-endian bytes per word with junk in the last low nibble
  function automatic logic [7:0] byteOf(input int idx);
    tWord w;
    w = image[idx / 5];
    case (idx % 5)
      0:       return w[35:28];
      1:       return w[27:20];
      2:       return w[19:12];
      3:       return w[11:4];
      default: return {w[3:0], 4'($urandom)};
    endcase
  endfunction

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset, start pulse and end of run
  initial begin
    arstN     = 1'b0;
    start     = 1'b0;
    byteValid = 1'b0;
    byteData  = '0;
    imageLen  = 0;
    cycleCnt  = 0;
    void'($urandom(32'h764f15e2));
    buildImage();
    // Script length plus a generous per-byte budget
    cycleLimit = 23 * (DiagHoldCycles + DiagGapCycles) + 10 * imageLen * 5 + 200;
    repeat (2) @(posedge CLK);
    #1 arstN = 1'b1;
    @(posedge CLK);
    #1 start = 1'b1;
    @(posedge CLK);
    #1 start = 1'b0;
    wait (checksDone);
    if (failCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Byte host
  // Spends one credit per byte and pauses at random
  initial begin
    int credits;
    int idx;
    credits = ByteFifoDepth;
    idx     = 0;
    wait (arstN);
    forever begin
      @(posedge CLK);
      #1;
      if (creditReturn) credits++;
      if (idx < imageLen * 5 && credits > 0 && ($urandom % 4) != 0) begin
        byteValid = 1'b1;
        byteData  = byteOf(idx);
        idx++;
        credits--;
      end else begin
        byteValid = 1'b0;
      end
    end
  end

  always @(posedge CLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
      $display("Timeout: boot did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule
